// File: adv_timer_settings.svh
`ifndef ADV_TIMER_SETTINGS_SVH
`define ADV_TIMER_SETTINGS_SVH

// ##################################################
// bus geometry
// ##################################################

`define ADV_NUM_TIMERS 4
`define ADV_APB_ADDR_W 12
`define ADV_DATA_W     32
`define ADV_IDX_LSB    2	// word index inside PADDR.
`define ADV_IDX_MSB    9

// ##################################################
// register map
// ##################################################

`define ADV_GLOBAL_SEL 4	// upper index nibble of the global block.
`define ADV_OFS_CMD    0
`define ADV_OFS_CFG    1
`define ADV_OFS_TH     2
`define ADV_OFS_CNT    11	// offsets 3 to 10 are unmapped.
`define ADV_OFS_CLK_EN 1

`endif

// File: apb_bus_pkg.sv
`default_nettype none
`include "adv_timer_settings.svh"

package apb_bus_pkg;

	// full APB address.
	typedef logic [`ADV_APB_ADDR_W-1:0] apb_addr_t;

	// word index, taken from PADDR with the byte offset dropped.
	typedef logic [`ADV_IDX_MSB-`ADV_IDX_LSB:0] reg_idx_t;

	// register offset, the lower nibble of the word index.
	typedef logic [3:0] reg_ofs_t;

	// bus data word.
	typedef logic [`ADV_DATA_W-1:0] word_t;

endpackage

`default_nettype wire

// File: timer_reg_pkg.sv
`default_nettype none
`include "adv_timer_settings.svh"

package timer_reg_pkg;

	// ##################################################
	// addressing
	// ##################################################

	// upper nibble of the word index, a timer number or the global block.
	typedef logic [3:0] timer_idx_t;

	// ##################################################
	// configuration fields
	// ##################################################

	typedef logic [7:0] in_sel_t;	// counter input select.

	typedef logic [2:0] in_mode_t;	// edge/level mode of the input.

	typedef logic [7:0] presc_t;	// prescaler value.

	// ##################################################
	// threshold and counter
	// ##################################################

	// one half of the 32-bit threshold word.
	typedef logic [15:0] half_th_t;

	// counter value seen on the readback path.
	typedef logic [15:0] counter_t;

endpackage

`default_nettype wire

// File: apb_reg_bridge.sv
`timescale 1ns/1ns
`default_nettype none
`include "adv_timer_settings.svh"

module apb_reg_bridge
	import apb_bus_pkg::*;
	import timer_reg_pkg::*;
(
	input  wire                            HCLK_i,
	input  wire                            HRESETn_i,
	input  wire apb_addr_t                 paddr_i,
	input  wire word_t                     pwdata_i,
	input  wire                            pwrite_i,
	input  wire                            psel_i,
	input  wire                            penable_i,
	output word_t                          prdata_o,
	output logic [`ADV_NUM_TIMERS-1:0]     timer_wr_o,
	output reg_ofs_t                       reg_ofs_o,
	output word_t                          wdata_o,
	input  wire word_t [`ADV_NUM_TIMERS-1:0] timer_rdata_i,
	output logic [`ADV_NUM_TIMERS-1:0]     clk_en_o
);

	reg_idx_t                      idx;
	timer_idx_t                    sel;
	reg_ofs_t                      ofs;
	logic                          wr_access;
	logic                          global_sel;
	logic                          clk_en_wr;
	logic [`ADV_NUM_TIMERS-1:0]    clk_en_q;

	// ##################################################
	// address decode
	// ##################################################

	assign idx = paddr_i[`ADV_IDX_MSB:`ADV_IDX_LSB];
	assign sel = idx[$bits(reg_idx_t)-1 -: $bits(timer_idx_t)];
	assign ofs = idx[$bits(reg_ofs_t)-1:0];

	assign wr_access  = psel_i & penable_i & pwrite_i;	// zero wait states.
	assign global_sel = (sel == timer_idx_t'(`ADV_GLOBAL_SEL));
	assign clk_en_wr  = wr_access & global_sel & (ofs == reg_ofs_t'(`ADV_OFS_CLK_EN));

	// one strobe per timer, shared offset and data.
	for (genvar t = 0; t < `ADV_NUM_TIMERS; t++) begin : g_wr
		assign timer_wr_o[t] = wr_access & (sel == timer_idx_t'(t));
	end

	assign reg_ofs_o = ofs;
	assign wdata_o   = pwdata_i;

	// ##################################################
	// global clock enable
	// ##################################################

	always_ff @(posedge HCLK_i or negedge HRESETn_i) begin
		if (!HRESETn_i) begin
			clk_en_q <= '0;
		end else if (clk_en_wr) begin
			clk_en_q <= pwdata_i[`ADV_NUM_TIMERS-1:0];	// one bit per timer.
		end
	end

	assign clk_en_o = clk_en_q;

	// ##################################################
	// read mux
	// ##################################################

	always_comb begin
		prdata_o = '0;
		if (global_sel) begin
			if (ofs == reg_ofs_t'(`ADV_OFS_CLK_EN)) begin
				prdata_o = word_t'(clk_en_q);
			end
		end else begin
			for (int i = 0; i < `ADV_NUM_TIMERS; i++) begin
				if (sel == timer_idx_t'(i)) begin
					prdata_o = timer_rdata_i[i];
				end
			end
		end
	end

	// the master must hold PSEL through the access phase.
	a_penable_needs_psel: assert property (
		@(posedge HCLK_i) disable iff (!HRESETn_i) penable_i |-> psel_i
	);

endmodule

`default_nettype wire

// File: timer_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "adv_timer_settings.svh"

module timer_regs
	import apb_bus_pkg::*;
	import timer_reg_pkg::*;
(
	input  wire           HCLK_i,
	input  wire           HRESETn_i,
	input  wire           wr_i,
	input  wire reg_ofs_t reg_ofs_i,
	input  wire word_t    wdata_i,
	input  wire counter_t counter_i,
	output word_t         rdata_o,
	output logic          start_o,
	output logic          stop_o,
	output logic          update_o,
	output logic          rst_o,
	output logic          arm_o,
	output logic          saw_o,
	output logic          in_clk_o,
	output in_mode_t      in_mode_o,
	output in_sel_t       in_sel_o,
	output presc_t        presc_o,
	output half_th_t      th_hi_o,
	output half_th_t      th_low_o
);

	// command word bits.
	localparam int CMD_START  = 0;
	localparam int CMD_STOP   = 1;
	localparam int CMD_UPDATE = 2;
	localparam int CMD_RST    = 3;
	localparam int CMD_ARM    = 4;
	localparam int CMD_W      = 5;

	// configuration word layout.
	localparam int IN_SEL_LSB  = 0;
	localparam int IN_MODE_LSB = 8;
	localparam int IN_CLK_BIT  = 11;
	localparam int SAW_BIT     = 12;
	localparam int PRESC_LSB   = 16;

	logic              cmd_wr;
	logic              cfg_wr;
	logic              th_wr;
	logic [CMD_W-1:0]  cmd_q;
	in_sel_t           in_sel_q;
	in_mode_t          in_mode_q;
	logic              in_clk_q;
	logic              saw_q;
	presc_t            presc_q;
	word_t             th_q;
	word_t             cfg_word;

	assign cmd_wr = wr_i & (reg_ofs_i == reg_ofs_t'(`ADV_OFS_CMD));
	assign cfg_wr = wr_i & (reg_ofs_i == reg_ofs_t'(`ADV_OFS_CFG));
	assign th_wr  = wr_i & (reg_ofs_i == reg_ofs_t'(`ADV_OFS_TH));

	// ##################################################
	// registers
	// ##################################################

	always_ff @(posedge HCLK_i or negedge HRESETn_i) begin
		if (!HRESETn_i) begin
			cmd_q     <= '0;
			in_sel_q  <= '0;
			in_mode_q <= '0;
			in_clk_q  <= 1'b0;
			saw_q     <= 1'b1;	// sawtooth by default.
			presc_q   <= '0;
			th_q      <= '0;
		end else begin
			cmd_q <= cmd_wr ? wdata_i[CMD_W-1:0] : '0;	// pulses last one cycle.
			if (cfg_wr) begin
				in_sel_q  <= wdata_i[IN_SEL_LSB +: $bits(in_sel_t)];
				in_mode_q <= wdata_i[IN_MODE_LSB +: $bits(in_mode_t)];
				in_clk_q  <= wdata_i[IN_CLK_BIT];
				saw_q     <= wdata_i[SAW_BIT];
				presc_q   <= wdata_i[PRESC_LSB +: $bits(presc_t)];
			end
			if (th_wr) begin
				th_q <= wdata_i;
			end
		end
	end

	assign start_o  = cmd_q[CMD_START];
	assign stop_o   = cmd_q[CMD_STOP];
	assign update_o = cmd_q[CMD_UPDATE];
	assign rst_o    = cmd_q[CMD_RST];
	assign arm_o    = cmd_q[CMD_ARM];

	assign in_sel_o  = in_sel_q;
	assign in_mode_o = in_mode_q;
	assign in_clk_o  = in_clk_q;
	assign saw_o     = saw_q;
	assign presc_o   = presc_q;
	assign th_hi_o   = th_q[$bits(word_t)-1 -: $bits(half_th_t)];
	assign th_low_o  = th_q[$bits(half_th_t)-1:0];

	// ##################################################
	// readback
	// ##################################################

	always_comb begin
		cfg_word = '0;
		cfg_word[IN_SEL_LSB +: $bits(in_sel_t)]   = in_sel_q;
		cfg_word[IN_MODE_LSB +: $bits(in_mode_t)] = in_mode_q;
		cfg_word[IN_CLK_BIT]                      = in_clk_q;
		cfg_word[SAW_BIT]                         = saw_q;
		cfg_word[PRESC_LSB +: $bits(presc_t)]     = presc_q;
	end

	always_comb begin
		case (reg_ofs_i)
			reg_ofs_t'(`ADV_OFS_CFG): rdata_o = cfg_word;
			reg_ofs_t'(`ADV_OFS_TH):  rdata_o = th_q;
			reg_ofs_t'(`ADV_OFS_CNT): rdata_o = word_t'(counter_i);
			default:                  rdata_o = '0;	// command word is write-only.
		endcase
	end

	// APB access phases are never adjacent, so no pulse may repeat.
	a_cmd_single_cycle: assert property (
		@(posedge HCLK_i) disable iff (!HRESETn_i) (|cmd_q) |=> !(|cmd_q)
	);

endmodule

`default_nettype wire

// File: adv_timer_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "adv_timer_settings.svh"

module adv_timer_regs
	import apb_bus_pkg::*;
	import timer_reg_pkg::*;
(
	input  wire                                 HCLK_i,
	input  wire                                 HRESETn_i,
	input  wire apb_addr_t                      PADDR_i,
	input  wire word_t                          PWDATA_i,
	input  wire                                 PWRITE_i,
	input  wire                                 PSEL_i,
	input  wire                                 PENABLE_i,
	output word_t                               PRDATA_o,
	output logic                                PREADY_o,
	output logic                                PSLVERR_o,
	input  wire counter_t [`ADV_NUM_TIMERS-1:0] timer_counter_i,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_start_o,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_stop_o,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_update_o,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_rst_o,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_arm_o,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_saw_o,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_in_clk_o,
	output in_mode_t [`ADV_NUM_TIMERS-1:0]      timer_in_mode_o,
	output in_sel_t [`ADV_NUM_TIMERS-1:0]       timer_in_sel_o,
	output presc_t [`ADV_NUM_TIMERS-1:0]        timer_presc_o,
	output half_th_t [`ADV_NUM_TIMERS-1:0]      timer_th_hi_o,
	output half_th_t [`ADV_NUM_TIMERS-1:0]      timer_th_low_o,
	output logic [`ADV_NUM_TIMERS-1:0]          timer_clk_en_o
);

	logic [`ADV_NUM_TIMERS-1:0]  timer_wr;
	reg_ofs_t                    reg_ofs;
	word_t                       wdata;
	word_t [`ADV_NUM_TIMERS-1:0] timer_rdata;

	assign PREADY_o  = 1'b1;	// zero wait states.
	assign PSLVERR_o = 1'b0;

	apb_reg_bridge u_bridge (
		.HCLK_i        (HCLK_i),
		.HRESETn_i     (HRESETn_i),
		.paddr_i       (PADDR_i),
		.pwdata_i      (PWDATA_i),
		.pwrite_i      (PWRITE_i),
		.psel_i        (PSEL_i),
		.penable_i     (PENABLE_i),
		.prdata_o      (PRDATA_o),
		.timer_wr_o    (timer_wr),
		.reg_ofs_o     (reg_ofs),
		.wdata_o       (wdata),
		.timer_rdata_i (timer_rdata),
		.clk_en_o      (timer_clk_en_o)
	);

	for (genvar t = 0; t < `ADV_NUM_TIMERS; t++) begin : g_timer
		timer_regs u_timer (
			.HCLK_i    (HCLK_i),
			.HRESETn_i (HRESETn_i),
			.wr_i      (timer_wr[t]),
			.reg_ofs_i (reg_ofs),
			.wdata_i   (wdata),
			.counter_i (timer_counter_i[t]),
			.rdata_o   (timer_rdata[t]),
			.start_o   (timer_start_o[t]),
			.stop_o    (timer_stop_o[t]),
			.update_o  (timer_update_o[t]),
			.rst_o     (timer_rst_o[t]),
			.arm_o     (timer_arm_o[t]),
			.saw_o     (timer_saw_o[t]),
			.in_clk_o  (timer_in_clk_o[t]),
			.in_mode_o (timer_in_mode_o[t]),
			.in_sel_o  (timer_in_sel_o[t]),
			.presc_o   (timer_presc_o[t]),
			.th_hi_o   (timer_th_hi_o[t]),
			.th_low_o  (timer_th_low_o[t])
		);
	end

endmodule

`default_nettype wire

// File: tb_adv_timer_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "adv_timer_settings.svh"

module tb_adv_timer_regs
	import apb_bus_pkg::*;
	import timer_reg_pkg::*;
();

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 16;
	localparam int NT           = `ADV_NUM_TIMERS;

	logic                HCLK = 1'b0;
	logic                HRESETn;
	apb_addr_t           paddr;
	word_t               pwdata;
	word_t               prdata;
	logic                pwrite;
	logic                psel;
	logic                penable;
	logic                pready;
	logic                pslverr;
	counter_t [NT-1:0]   timer_counter;
	logic [NT-1:0]       start;
	logic [NT-1:0]       stop;
	logic [NT-1:0]       update;
	logic [NT-1:0]       rst;
	logic [NT-1:0]       arm;
	logic [NT-1:0]       saw;
	logic [NT-1:0]       in_clk;
	logic [NT-1:0]       clk_en;
	in_mode_t [NT-1:0]   in_mode;
	in_sel_t [NT-1:0]    in_sel;
	presc_t [NT-1:0]     presc;
	half_th_t [NT-1:0]   th_hi;
	half_th_t [NT-1:0]   th_low;
	int                  line_count = 0;
	bit                  lines_counted = 1'b0;

	adv_timer_regs uut (
		.HCLK_i          (HCLK),
		.HRESETn_i       (HRESETn),
		.PADDR_i         (paddr),
		.PWDATA_i        (pwdata),
		.PWRITE_i        (pwrite),
		.PSEL_i          (psel),
		.PENABLE_i       (penable),
		.PRDATA_o        (prdata),
		.PREADY_o        (pready),
		.PSLVERR_o       (pslverr),
		.timer_counter_i (timer_counter),
		.timer_start_o   (start),
		.timer_stop_o    (stop),
		.timer_update_o  (update),
		.timer_rst_o     (rst),
		.timer_arm_o     (arm),
		.timer_saw_o     (saw),
		.timer_in_clk_o  (in_clk),
		.timer_in_mode_o (in_mode),
		.timer_in_sel_o  (in_sel),
		.timer_presc_o   (presc),
		.timer_th_hi_o   (th_hi),
		.timer_th_low_o  (th_low),
		.timer_clk_en_o  (clk_en)
	);

	initial begin
		forever #(CLK_PERIOD/2) HCLK = ~HCLK;
	end

	// ##################################################
	// helpers
	// ##################################################

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		assert (actual === expected) else begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			abort_run("stopping at the first mismatch.");
		end
	endtask

	// setup and access phase of one cycle each, read data and handshake taken mid-access.
	task automatic apb_transfer(input logic write, input reg_idx_t idx, input word_t data,
			output word_t rdata);
		@(negedge HCLK);
		paddr   = apb_addr_t'({idx, 2'b00});
		pwrite  = write;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge HCLK);
		penable = 1'b1;
		#(CLK_PERIOD/4);
		rdata = prdata;
		check_value("PREADY", word_t'(pready), word_t'(1'b1));
		check_value("PSLVERR", word_t'(pslverr), '0);
		@(negedge HCLK);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	function automatic logic [4:0] pulse_mask(input int t);
		return {arm[t], rst[t], update[t], stop[t], start[t]};
	endfunction

	function automatic word_t output_field(input int code, input int t);
		case (code)
			0:       return word_t'(saw[t]);
			1:       return word_t'(in_clk[t]);
			2:       return word_t'(in_mode[t]);
			3:       return word_t'(in_sel[t]);
			4:       return word_t'(presc[t]);
			5:       return word_t'(th_hi[t]);
			6:       return word_t'(th_low[t]);
			default: return word_t'(clk_en[t]);
		endcase
	endfunction

	function automatic string field_name(input int code, input int t);
		string names [8] = '{"timer_saw_o", "timer_in_clk_o", "timer_in_mode_o",
			"timer_in_sel_o", "timer_presc_o", "timer_th_hi_o", "timer_th_low_o",
			"timer_clk_en_o"};
		return $sformatf("%s[%0d]", names[code & 7], t);
	endfunction

	// ##################################################
	// watchdog
	// ##################################################

	initial begin
		wait (lines_counted);
		#((line_count * 10 + RESET_CYCLES) * CLK_PERIOD);
		abort_run("timeout: the tests did not finish in time.");
	end

	// ##################################################
	// test sequence
	// ##################################################

	initial begin
		int                 fd;
		int                 n;
		logic [63:0]        op;
		logic [8*128-1:0]   rest;
		reg_idx_t           idx;
		word_t              data;
		word_t              expected;
		word_t              rd;
		logic [4:0]         exp_mask;
		bit                 done;

		HRESETn = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		pwrite  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		done    = 1'b0;
		void'($urandom(45));
		for (int i = 0; i < NT; i++) begin
			timer_counter[i] = counter_t'($urandom);	// counters not set by the file.
		end

		fd = $fopen("adv_timer_regs_tests.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the tests file.");
		end
		while (!$feof(fd)) begin
			if ($fgets(rest, fd) != 0) begin
				line_count++;
			end
		end
		$fclose(fd);
		lines_counted = 1'b1;
		fd = $fopen("adv_timer_regs_tests.txt", "r");

		repeat (RESET_CYCLES) @(negedge HCLK);
		HRESETn = 1'b1;

		while (!done) begin
			n = $fscanf(fd, "%s", op);
			if (n != 1) begin
				done = 1'b1;
			end else if (op[7:0] == "#") begin
				void'($fgets(rest, fd));	// comment line.
			end else begin
				n = $fscanf(fd, "%h %h %h", idx, data, expected);
				if (n != 3) begin
					abort_run("malformed line in the tests file.");
				end
				case (op[7:0])
					"W": apb_transfer(1'b1, idx, data, rd);
					"R": begin
						apb_transfer(1'b0, idx, '0, rd);
						// counter offsets read the driven input, zero-extended.
						if (idx[3:0] == reg_ofs_t'(`ADV_OFS_CNT) && int'(idx[7:4]) < NT) begin
							expected = word_t'(timer_counter[idx[7:4]]);
						end
						check_value("PRDATA", rd, expected);
					end
					"C": begin
						@(negedge HCLK);
						timer_counter[idx] = counter_t'(data);
					end
					"P": begin
						for (int i = 0; i < NT; i++) begin
							exp_mask = (i == int'(idx)) ? expected[4:0] : 5'b0;
							check_value($sformatf("timer %0d pulses", i),
								word_t'(pulse_mask(i)), word_t'(exp_mask));
						end
						@(negedge HCLK);
						for (int i = 0; i < NT; i++) begin
							check_value($sformatf("timer %0d pulses", i),
								word_t'(pulse_mask(i)), '0);
						end
					end
					"O": check_value(field_name(int'(data), int'(idx)),
						output_field(int'(data), int'(idx)), expected);
					default: abort_run("unknown operation in the tests file.");
				endcase
			end
		end
		$fclose(fd);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: adv_timer_regs_tests.txt
# op idx data expected, hex; W write, R read PRDATA, C counter of timer idx = data
# P pulses of timer idx = expected; O timer idx field data (0 saw .. 7 clk_en); R of counter checks input
R 01 0 00001000
R 31 0 00001000
R 02 0 00000000
R 32 0 00000000
R 41 0 00000000
O 0 0 1
O 3 0 1
W 01 ffffffff 0
R 01 0 00ff1fff
O 0 3 ff
O 0 2 7
O 0 4 ff
R 11 0 00001000
W 21 00a50e3c 0
R 21 0 00a50e3c
O 2 0 0
O 2 1 1
O 1 0 1
W 32 12345678 0
R 32 0 12345678
O 3 5 1234
O 3 6 5678
W 10 00000015 0
P 1 0 15
W 30 0000000a 0
P 3 0 0a
R 10 0 00000000
C 2 0000beef 0
R 2b 0 00000000
R 0b 0 00000000
W 41 0000000a 0
R 41 0 0000000a
O 1 7 1
O 0 7 0
W 05 ffffffff 0
R 05 0 00000000
R 46 0 00000000
W 51 ffffffff 0
R 51 0 00000000
R 01 0 00ff1fff

// File: files.f
+incdir+.
apb_bus_pkg.sv
timer_reg_pkg.sv
apb_reg_bridge.sv
timer_regs.sv
adv_timer_regs.sv
tb_adv_timer_regs.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_adv_timer_regs \
	&& ./obj_dir/Vtb_adv_timer_regs | tee /dev/stderr | grep -F -q 'All tests passed!' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
